// ==== common/adc_sync_pkg.sv ====
package adc_sync_pkg;

// Vector types
// ====================

// Delay counter and its thresholds
typedef logic [31:0] delay_count_t;

typedef logic [1:0] phase_sel_t;     // 0 = 0, 1 = 90, 2 = 180, 3 = 270 degrees
typedef logic [3:0] phase_bits_t;    // Snapshot of second ADC clock
typedef logic [15:0] sample_count_t; // Stability run length

// Controller states
// ====================
typedef enum logic [2:0] {
	st_init,
	st_reset_adc,
	st_wait_adc,
	st_wait_lock,
	st_sample,
	st_decide,
	st_done
} sync_state_t;

// Bit positions inside phase_bits_t
localparam int PHASE_0   = 0;
localparam int PHASE_90  = 1;
localparam int PHASE_180 = 2;
localparam int PHASE_270 = 3;

endpackage

// ==== verilog/delay_timer.sv ====
`timescale 1ns/10ps
module delay_timer #(
	parameter adc_sync_pkg::delay_count_t INIT_DELAY = 32'd125_000_000,
	parameter adc_sync_pkg::delay_count_t ADC_WAIT_DELAY = 32'd2000
) (
	input  logic dcm_psclk,
	input  logic ctrl_reset,
	input  logic timer_clear,
	output logic init_elapsed,
	output logic wait_elapsed
);

// Delay counter
// ====================
adc_sync_pkg::delay_count_t delay_count;

// Restarts from zero whenever the FSM clears it
always_ff @(posedge dcm_psclk) begin
	if (ctrl_reset || timer_clear) begin
		delay_count <= '0;
	end else begin
		delay_count <= delay_count + 32'd1;
	end
end

// Threshold compares
// ====================

// Power-up wait
assign init_elapsed = (delay_count > INIT_DELAY);

assign wait_elapsed = (delay_count > ADC_WAIT_DELAY); // ADC settling

endmodule

// ==== verilog/reset_pulser.sv ====
`timescale 1ns/10ps
module reset_pulser #(
	parameter adc_sync_pkg::delay_count_t RESET_PULSE_CYCLES = 32'd16
) (
	input  logic dcm_psclk,
	input  logic ctrl_reset,
	input  logic reset_start,
	output logic adc1_reset,
	output adc_sync_pkg::phase_sel_t reset_phase
);

// Wide enough to hold the full pulse width
localparam int PULSE_W = $clog2(RESET_PULSE_CYCLES + 1);

adc_sync_pkg::phase_sel_t attempt_phase; // Phase for the next attempt
logic [PULSE_W-1:0] pulse_cnt;           // Cycles of reset still to go

// Attempt phase
// ====================

// Each start takes the current phase and moves on to the next one
always_ff @(posedge dcm_psclk) begin
	if (ctrl_reset) begin
		attempt_phase <= '0;
		reset_phase <= '0;
	end else if (reset_start) begin
		reset_phase <= attempt_phase;
		attempt_phase <= attempt_phase + 2'd1; // Wraps after 270 degrees
	end
end

// Pulse width
// ====================
always_ff @(posedge dcm_psclk) begin
	if (ctrl_reset) begin
		pulse_cnt <= '0;
	end else if (reset_start) begin
		pulse_cnt <= PULSE_W'(RESET_PULSE_CYCLES);
	end else if (pulse_cnt != '0) begin
		pulse_cnt <= pulse_cnt - 1'b1;
	end
end

// High from the cycle after the start until the count runs out
assign adc1_reset = (pulse_cnt != '0);

endmodule

// ==== verilog/phase_sampler.sv ====
`timescale 1ns/10ps
module phase_sampler #(
	parameter adc_sync_pkg::sample_count_t SAMPLE_COUNT = 16'd64
) (
	input  logic dcm_psclk,
	input  logic ctrl_reset,
	input  logic sampler_clear,
	input  logic sample_req,
	input  adc_sync_pkg::phase_bits_t phase_bits,
	output logic sample_valid,
	output adc_sync_pkg::phase_bits_t phase_result
);

adc_sync_pkg::phase_bits_t prev_bits;   // Snapshot from last cycle
adc_sync_pkg::sample_count_t run_cnt;   // Equal snapshots so far
adc_sync_pkg::sample_count_t run_next;
logic bits_equal;

// Run tracking
// ====================
assign bits_equal = (phase_bits == prev_bits);

// Any change in the snapshot starts the run over
assign run_next = bits_equal ? run_cnt + 16'd1 : '0;

always_ff @(posedge dcm_psclk) begin
	if (ctrl_reset) begin
		prev_bits <= '0;
	end else begin
		prev_bits <= phase_bits;
	end
end

// Capture
// ====================

// Counting stops once a stable pattern is held
always_ff @(posedge dcm_psclk) begin
	if (ctrl_reset || sampler_clear) begin
		run_cnt <= '0;
		sample_valid <= 1'b0;
		phase_result <= '0;
	end else if (sample_req && !sample_valid) begin
		run_cnt <= run_next;
		if (run_next == SAMPLE_COUNT) begin
			phase_result <= phase_bits; // Pattern held long enough
			sample_valid <= 1'b1;
		end
	end
end

endmodule

// ==== verilog/sync_fsm.sv ====
`timescale 1ns/10ps
module sync_fsm (
	input  logic dcm_psclk,
	input  logic ctrl_reset,
	input  logic init_elapsed,
	input  logic wait_elapsed,
	input  logic dcm0_locked,
	input  logic dcm1_locked,
	input  logic sample_valid,
	input  adc_sync_pkg::phase_bits_t phase_result,
	output logic timer_clear,
	output logic reset_start,
	output logic sampler_clear,
	output logic sample_req,
	output logic sync_done
);

adc_sync_pkg::sync_state_t state;
adc_sync_pkg::sync_state_t next_state;
logic phase_good;

// Alignment rule
// ====================

// 90 degrees high together with its 0 or 180 degree neighbour
assign phase_good = phase_result[adc_sync_pkg::PHASE_90] &&
	(phase_result[adc_sync_pkg::PHASE_180] || phase_result[adc_sync_pkg::PHASE_0]);

// State register
// ====================
always_ff @(posedge dcm_psclk) begin
	if (ctrl_reset) begin
		state <= adc_sync_pkg::st_init;
	end else begin
		state <= next_state;
	end
end

// Next state and strobes
// ====================
always_comb begin
	next_state = state;
	timer_clear = 1'b0;
	reset_start = 1'b0;
	sampler_clear = 1'b0;
	sample_req = 1'b0;
	sync_done = 1'b0;
	case (state)
		adc_sync_pkg::st_init: begin
			if (init_elapsed) begin // Power-up wait over
				next_state = adc_sync_pkg::st_reset_adc;
			end
		end

		// Single cycle, restarts the timer for the settling wait
		adc_sync_pkg::st_reset_adc: begin
			reset_start = 1'b1;
			timer_clear = 1'b1;
			next_state = adc_sync_pkg::st_wait_adc;
		end

		adc_sync_pkg::st_wait_adc: begin
			if (wait_elapsed) begin
				next_state = adc_sync_pkg::st_wait_lock;
			end
		end

		adc_sync_pkg::st_wait_lock: begin
			sampler_clear = 1'b1; // Fresh sample per attempt
			if (dcm0_locked && dcm1_locked) begin
				next_state = adc_sync_pkg::st_sample;
			end
		end

		adc_sync_pkg::st_sample: begin
			sample_req = 1'b1;
			if (sample_valid) begin
				next_state = adc_sync_pkg::st_decide;
			end
		end

		adc_sync_pkg::st_decide: begin
			timer_clear = 1'b1;
			sampler_clear = 1'b1;
			if (phase_good) begin
				next_state = adc_sync_pkg::st_done;
			end else begin
				next_state = adc_sync_pkg::st_reset_adc; // Retry on next phase
			end
		end

		// Held until the next reset
		adc_sync_pkg::st_done: begin
			sync_done = 1'b1;
		end

		default: begin
			next_state = adc_sync_pkg::st_init;
		end
	endcase
end

endmodule

// ==== verilog/adc_sync_top.sv ====
`timescale 1ns/10ps
module adc_sync_top #(
	parameter adc_sync_pkg::delay_count_t INIT_DELAY = 32'd125_000_000,
	parameter adc_sync_pkg::delay_count_t ADC_WAIT_DELAY = 32'd2000,
	parameter adc_sync_pkg::delay_count_t RESET_PULSE_CYCLES = 32'd16,
	parameter adc_sync_pkg::sample_count_t SAMPLE_COUNT = 16'd64
) (
	input  logic dcm_psclk,
	input  logic ctrl_reset,
	input  logic dcm0_locked,
	input  logic dcm1_locked,
	input  adc_sync_pkg::phase_bits_t phase_bits,
	output logic adc1_reset,
	output adc_sync_pkg::phase_sel_t reset_phase,
	output logic sync_done
);

// Internal wires
// ====================
logic timer_clear;
logic init_elapsed;
logic wait_elapsed;
logic reset_start;
logic sampler_clear;
logic sample_req;
logic sample_valid;
adc_sync_pkg::phase_bits_t phase_result;

// Blocks
// ====================
delay_timer #(
	.INIT_DELAY(INIT_DELAY),
	.ADC_WAIT_DELAY(ADC_WAIT_DELAY)
) delay_timer_inst (
	.dcm_psclk(dcm_psclk),
	.ctrl_reset(ctrl_reset),
	.timer_clear(timer_clear),
	.init_elapsed(init_elapsed),
	.wait_elapsed(wait_elapsed)
);

// Second ADC reset, one pulse per attempt
reset_pulser #(
	.RESET_PULSE_CYCLES(RESET_PULSE_CYCLES)
) reset_pulser_inst (
	.dcm_psclk(dcm_psclk),
	.ctrl_reset(ctrl_reset),
	.reset_start(reset_start),
	.adc1_reset(adc1_reset),
	.reset_phase(reset_phase)
);

phase_sampler #(
	.SAMPLE_COUNT(SAMPLE_COUNT)
) phase_sampler_inst (
	.dcm_psclk(dcm_psclk),
	.ctrl_reset(ctrl_reset),
	.sampler_clear(sampler_clear),
	.sample_req(sample_req),
	.phase_bits(phase_bits),
	.sample_valid(sample_valid),
	.phase_result(phase_result)
);

sync_fsm sync_fsm_inst (
	.dcm_psclk(dcm_psclk),
	.ctrl_reset(ctrl_reset),
	.init_elapsed(init_elapsed),
	.wait_elapsed(wait_elapsed),
	.dcm0_locked(dcm0_locked),
	.dcm1_locked(dcm1_locked),
	.sample_valid(sample_valid),
	.phase_result(phase_result),
	.timer_clear(timer_clear),
	.reset_start(reset_start),
	.sampler_clear(sampler_clear),
	.sample_req(sample_req),
	.sync_done(sync_done)
);

endmodule

// ==== bench/adc_sync_tb.sv ====
`timescale 1ns/10ps
module adc_sync_tb;

// Setup
// ====================
localparam adc_sync_pkg::delay_count_t INIT_DELAY = 32'd20;
localparam adc_sync_pkg::delay_count_t ADC_WAIT_DELAY = 32'd40;
localparam adc_sync_pkg::delay_count_t RESET_PULSE_CYCLES = 32'd4;
localparam adc_sync_pkg::sample_count_t SAMPLE_COUNT = 16'd8;
localparam int NUM_TESTS = 5;
localparam int STEP_LIMIT = INIT_DELAY + ADC_WAIT_DELAY + SAMPLE_COUNT + 10;
localparam int TIMEOUT_CYCLES =
	(INIT_DELAY + 4 * (ADC_WAIT_DELAY + SAMPLE_COUNT + 10)) * NUM_TESTS * 2;

logic dcm_psclk = 1'b0;
logic ctrl_reset;
logic dcm0_locked;
logic dcm1_locked;
adc_sync_pkg::phase_bits_t phase_bits;
logic adc1_reset;
adc_sync_pkg::phase_sel_t reset_phase;
logic sync_done;

int mismatch_count = 0;
int failure_count = 0;
int check_total = 0;
int cycle_count = 0;
int pulse_total = 0; // Rising edges of adc1_reset since reset
logic last_adc_reset = 1'b0;
integer seed = 32'hbf95_9582;

adc_sync_top #(
	.INIT_DELAY(INIT_DELAY),
	.ADC_WAIT_DELAY(ADC_WAIT_DELAY),
	.RESET_PULSE_CYCLES(RESET_PULSE_CYCLES),
	.SAMPLE_COUNT(SAMPLE_COUNT)
) adc_sync_top_inst (
	.dcm_psclk(dcm_psclk),
	.ctrl_reset(ctrl_reset),
	.dcm0_locked(dcm0_locked),
	.dcm1_locked(dcm1_locked),
	.phase_bits(phase_bits),
	.adc1_reset(adc1_reset),
	.reset_phase(reset_phase),
	.sync_done(sync_done)
);

always #2 dcm_psclk = ~dcm_psclk; // 4 ns period

// Watchdog
always @(posedge dcm_psclk) begin
	cycle_count <= cycle_count + 1;
	if (cycle_count >= TIMEOUT_CYCLES) begin
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$finish;
	end
end

// Counts adc1_reset pulses on the rising edge
always @(posedge dcm_psclk) begin
	last_adc_reset <= adc1_reset;
	if (ctrl_reset) begin
		pulse_total <= 0;
	end else if (adc1_reset && !last_adc_reset) begin
		pulse_total <= pulse_total + 1;
	end
end

// Compare tasks
// ====================
task automatic check_bit(input string what, input logic got, input logic exp);
	check_total++;
	if (got !== exp) begin
		mismatch_count++;
		$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic check_phase(input string what, input adc_sync_pkg::phase_sel_t got,
		input adc_sync_pkg::phase_sel_t exp);
	check_total++;
	if (got !== exp) begin
		mismatch_count++;
		$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
	end
endtask

task automatic check_count(input string what, input adc_sync_pkg::delay_count_t got,
		input adc_sync_pkg::delay_count_t exp);
	check_total++;
	if (got !== exp) begin
		mismatch_count++;
		$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
	end
endtask

// Helpers
// ====================
task automatic apply_reset();
	@(negedge dcm_psclk);
	ctrl_reset = 1'b1;
	repeat (4) @(negedge dcm_psclk);
	ctrl_reset = 1'b0;
endtask

task automatic wait_for_pulse(input string what);
	int waited;
	waited = 0;
	while (!adc1_reset && waited < STEP_LIMIT) begin
		@(negedge dcm_psclk);
		waited++;
	end
	if (!adc1_reset) begin
		failure_count++;
		$display("no reset pulse for %s within %0d cycles", what, STEP_LIMIT);
	end
endtask

// Called on the first high cycle, returns on the first low one
task automatic measure_pulse(output adc_sync_pkg::delay_count_t width);
	width = 0;
	while (adc1_reset && width < 4 * RESET_PULSE_CYCLES) begin
		width = width + 1;
		@(negedge dcm_psclk);
	end
endtask

task automatic wait_for_done(input string what);
	int waited;
	waited = 0;
	while (!sync_done && waited < STEP_LIMIT) begin
		@(negedge dcm_psclk);
		waited++;
	end
	if (!sync_done) begin
		failure_count++;
		$display("sync_done did not rise in %s within %0d cycles", what, STEP_LIMIT);
	end
endtask

// Tests
// ====================
task automatic test_power_up_quiet();
	dcm0_locked = 1'b1;
	dcm1_locked = 1'b1;
	phase_bits = 4'b0110;
	apply_reset();
	repeat (INIT_DELAY) begin
		@(negedge dcm_psclk);
		check_bit("adc1_reset during power-up", adc1_reset, 1'b0);
		check_bit("sync_done during power-up", sync_done, 1'b0);
		check_phase("reset_phase during power-up", reset_phase, 2'd0);
	end
endtask

task automatic test_first_pulse();
	adc_sync_pkg::delay_count_t width;
	apply_reset();
	wait_for_pulse("first attempt");
	check_phase("reset_phase of first pulse", reset_phase, 2'd0);
	measure_pulse(width);
	check_count("first pulse width", width, RESET_PULSE_CYCLES);
endtask

task automatic test_lock_wait();
	adc_sync_pkg::delay_count_t width;
	dcm1_locked = 1'b0;
	phase_bits = (1 << adc_sync_pkg::PHASE_90) | (1 << adc_sync_pkg::PHASE_180);
	apply_reset();
	wait_for_pulse("lock wait");
	measure_pulse(width);
	check_count("pulse width before lock", width, RESET_PULSE_CYCLES);
	repeat (ADC_WAIT_DELAY + 4 * SAMPLE_COUNT) begin
		@(negedge dcm_psclk);
		check_bit("sync_done without lock", sync_done, 1'b0);
		check_bit("adc1_reset without lock", adc1_reset, 1'b0);
	end
	dcm1_locked = 1'b1;
	wait_for_done("lock wait");
	check_count("pulses until sync", pulse_total, 32'd1);
endtask

task automatic test_phase_rotation();
	adc_sync_pkg::delay_count_t width;
	phase_bits = 1 << adc_sync_pkg::PHASE_270; // Never aligned
	apply_reset();
	for (int k = 0; k < 5; k++) begin
		wait_for_pulse("phase rotation");
		check_phase("reset_phase of retry", reset_phase, adc_sync_pkg::phase_sel_t'(k % 4));
		measure_pulse(width);
		check_count("retry pulse width", width, RESET_PULSE_CYCLES);
	end
	phase_bits = (1 << adc_sync_pkg::PHASE_0) | (1 << adc_sync_pkg::PHASE_90);
	wait_for_done("phase rotation");
	repeat (ADC_WAIT_DELAY + SAMPLE_COUNT) begin
		@(negedge dcm_psclk);
		check_bit("adc1_reset after sync", adc1_reset, 1'b0);
		check_bit("sync_done held", sync_done, 1'b1);
	end
	check_count("pulses in rotation", pulse_total, 32'd5);
endtask

task automatic test_unstable_bits();
	adc_sync_pkg::delay_count_t width;
	adc_sync_pkg::phase_bits_t next_bits;
	phase_bits = '0;
	apply_reset();
	wait_for_pulse("unstable bits");
	measure_pulse(width);
	repeat (ADC_WAIT_DELAY + 4 * SAMPLE_COUNT) begin
		next_bits = adc_sync_pkg::phase_bits_t'($random(seed));
		if (next_bits == phase_bits) begin
			next_bits = ~next_bits; // Force a change every cycle
		end
		phase_bits = next_bits;
		@(negedge dcm_psclk);
		check_bit("sync_done with jittery bits", sync_done, 1'b0);
	end
	phase_bits = (1 << adc_sync_pkg::PHASE_90) | (1 << adc_sync_pkg::PHASE_180);
	wait_for_done("unstable bits");
	check_count("pulses with jittery bits", pulse_total, 32'd1);
endtask

initial begin
	ctrl_reset = 1'b1;
	dcm0_locked = 1'b0;
	dcm1_locked = 1'b0;
	phase_bits = '0;
	test_power_up_quiet();
	test_first_pulse();
	test_lock_wait();
	test_phase_rotation();
	test_unstable_bits();
	$display("%0d checks, %0d mismatches, %0d other errors",
		check_total, mismatch_count, failure_count);
	if (mismatch_count == 0 && failure_count == 0) begin
		$display("Test OK");
	end else begin
		$display("Test FAILED");
	end
	$finish;
end

endmodule

// ==== verilog.f ====
common/adc_sync_pkg.sv
verilog/delay_timer.sv
verilog/reset_pulser.sv
verilog/phase_sampler.sv
verilog/sync_fsm.sv
verilog/adc_sync_top.sv
bench/adc_sync_tb.sv

// ==== Bender.yml ====
package:
  name: adc_sync

sources:
  - common/adc_sync_pkg.sv
  - verilog/delay_timer.sv
  - verilog/reset_pulser.sv
  - verilog/phase_sampler.sv
  - verilog/sync_fsm.sv
  - verilog/adc_sync_top.sv
  - target: simulation
    files:
      - bench/adc_sync_tb.sv
